// File: logic/videoPkg.sv
//------------------------------
// Shared geometry, depths and types of the video transmit path
// Imported by every stage of videoTxUnit
//------------------------------
package videoPkg;

	//------------------------------
	// Panel timing, counted in sClk cycles and lines
	//------------------------------
	localparam int hActive    = 16;
	localparam int hSyncStart = 18;
	localparam int hSyncEnd   = 20;
	localparam int hTotal     = 24;
	localparam int vActive    = 8;
	localparam int vSyncStart = 9;
	localparam int vSyncEnd   = 10;
	localparam int vTotal     = 11;

	// One whole active frame
	localparam int frameWords = 128;
	// Display side pixel FIFO
	localparam int fifoDepth  = 16;

	//------------------------------
	// Vector types
	//------------------------------
	// ARGB4444, alpha in the top nibble
	typedef logic [15:0] pixelT;
	typedef logic [3:0]  colorT;
	typedef logic [4:0]  hCountT;
	typedef logic [3:0]  vCountT;
	typedef logic [6:0]  fbAdrsT;
	// Holds 0 up to fifoDepth
	typedef logic [4:0]  creditT;
	typedef logic [7:0]  dutyT;

	// Owner of the frame buffer port in one cycle
	typedef enum logic [1:0] {opIdle, opWrite, opRead} dmaOpT;

endpackage

// File: logic/videoPixelGen.sv
//------------------------------
// Raster test pattern source for the frame buffer DMA
// Alpha channel follows the scene fade controls
//------------------------------
module videoPixelGen import videoPkg::*;
(
	input  logic       sClk,
	input  logic       rst,
	input  logic       dmaEn,
	input  logic       sceneFadeIn,
	input  logic       sceneFadeOut,
	input  logic [6:0] sceneStep,
	input  logic       dmaFull,
	output pixelT      pixel,
	output logic       pixelWe,
	output logic       sceneAlphaMax,
	output logic       sceneAlphaMin
);

hCountT     x;
vCountT     y;
colorT      alpha;
logic [6:0] frameCnt;
logic       lastX;
logic       lastY;
logic       frameWrap;
logic       stepNow;

// Transfer whenever the DMA has room
assign pixelWe = dmaEn && !dmaFull;

assign lastX     = (x == hCountT'(hActive - 1));
assign lastY     = (y == vCountT'(vActive - 1));
// Last pixel of a generated frame goes out this cycle
assign frameWrap = pixelWe && lastX && lastY;
assign stepNow   = ((frameCnt + 7'd1) >= sceneStep);

//------------------------------
// Raster position
//------------------------------
always_ff @(posedge sClk)
begin
	if (rst)
	begin
		x <= '0;
		y <= '0;
	end
	else if (pixelWe)
	begin
		if (lastX)
		begin
			x <= '0;
			y <= lastY ? '0 : y + 1'b1;
		end
		else
			x <= x + 1'b1;
	end
end

//------------------------------
// Scene fade, one step per sceneStep frames
//------------------------------
always_ff @(posedge sClk)
begin
	if (rst)
	begin
		alpha    <= '0;
		frameCnt <= '0;
	end
	else if (frameWrap)
	begin
		if (stepNow)
		begin
			frameCnt <= '0;
			// Saturate at both ends
			if (sceneFadeIn && alpha != 4'hF)
				alpha <= alpha + 1'b1;
			else if (sceneFadeOut && alpha != 4'h0)
				alpha <= alpha - 1'b1;
		end
		else
			frameCnt <= frameCnt + 1'b1;
	end
end

assign sceneAlphaMax = (alpha == 4'hF);
assign sceneAlphaMin = (alpha == 4'h0);

// A | R = y | G = x | B = x ^ y
assign pixel = {alpha, colorT'(y), colorT'(x), colorT'(x) ^ colorT'(y)};

endmodule

// File: logic/videoDma.sv
//------------------------------
// Frame buffer DMA between pixel generator and pixel FIFO
// One shared RAM port, read side throttled by FIFO credits
//------------------------------
module videoDma import videoPkg::*;
(
	input  logic  sClk,
	input  logic  rst,
	input  pixelT pixel,
	input  logic  pixelWe,
	input  logic  memRdy,
	input  logic  creditRet,
	output logic  dmaFull,
	output pixelT fifoWd,
	output logic  fifoWe
);

localparam int fillBits = $clog2(frameWords) + 1;

pixelT               fbRam [frameWords];
fbAdrsT              wrPtr;
fbAdrsT              rdPtr;
// Written words not yet scanned out
logic [fillBits-1:0] fillCount;
// First complete frame is in the RAM
logic                frameValid;
creditT              creditCnt;
// Holding slot for a pixel that lost arbitration
pixelT               inPixel;
logic                inValid;
dmaOpT               dmaOp;
logic                wrReq;
logic                rdReq;
pixelT               wrData;

// Stall the generator on a full RAM or a parked pixel
assign dmaFull = inValid || (fillCount == fillBits'(frameWords));

//------------------------------
// Requests and port arbiter
//------------------------------
always_comb
begin
	wrReq  = (inValid || pixelWe) && (fillCount < fillBits'(frameWords));
	wrData = inValid ? inPixel : pixel;
	// Read issued last cycle still owns a credit until its push
	rdReq  = frameValid && (creditCnt > creditT'(fifoWe));
end

always_comb
begin
	dmaOp = opIdle;
	if (memRdy)
	begin
		// Display side first
		if (rdReq)
			dmaOp = opRead;
		else if (wrReq)
			dmaOp = opWrite;
	end
end

//------------------------------
// Frame buffer RAM, registered read
//------------------------------
always_ff @(posedge sClk)
begin
	if (dmaOp == opWrite)
		fbRam[wrPtr] <= wrData;
	if (dmaOp == opRead)
		fifoWd <= fbRam[rdPtr];
end

// Park the incoming pixel
always_ff @(posedge sClk)
begin
	if (pixelWe && !inValid)
		inPixel <= pixel;
end

//------------------------------
// Pointers, occupancy and credits
//------------------------------
always_ff @(posedge sClk)
begin
	if (rst)
	begin
		inValid    <= 1'b0;
		wrPtr      <= '0;
		rdPtr      <= '0;
		fillCount  <= '0;
		frameValid <= 1'b0;
		creditCnt  <= creditT'(fifoDepth);
		fifoWe     <= 1'b0;
	end
	else
	begin
		if (dmaOp == opWrite)
			inValid <= 1'b0;
		else if (pixelWe)
			inValid <= 1'b1;

		if (dmaOp == opWrite)
		begin
			wrPtr     <= wrPtr + 1'b1;
			fillCount <= fillCount + 1'b1;
			if (wrPtr == fbAdrsT'(frameWords - 1))
				frameValid <= 1'b1;
		end

		// Scan keeps cycling the stored frame when the writer lags,
		// so the panel repeats old pixels instead of starving
		if (dmaOp == opRead)
		begin
			rdPtr <= rdPtr + 1'b1;
			if (fillCount != '0)
				fillCount <= fillCount - 1'b1;
		end

		// Push lands one cycle after the read
		fifoWe    <= (dmaOp == opRead);
		creditCnt <= creditCnt + creditT'(creditRet) - creditT'(fifoWe);
	end
end

endmodule

// File: logic/videoPixelFifo.sv
//------------------------------
// Display side pixel FIFO, single clock
// Pops return a credit to the DMA, empty pops raise underrun
//------------------------------
module videoPixelFifo import videoPkg::*;
(
	input  logic  sClk,
	input  logic  rst,
	input  pixelT fifoWd,
	input  logic  fifoWe,
	input  logic  pixelPop,
	output pixelT rdPixel,
	output logic  creditRet,
	output logic  primed,
	output logic  underrun
);

localparam int ptrBits = $clog2(fifoDepth);

pixelT              mem [fifoDepth];
logic [ptrBits-1:0] wrPtr;
logic [ptrBits-1:0] rdPtr;
logic [ptrBits:0]   level;
// Pop that finds data
logic               popOk;

assign popOk = pixelPop && (level != '0);

//------------------------------
// Storage and read port
//------------------------------
always_ff @(posedge sClk)
begin
	if (fifoWe)
		mem[wrPtr] <= fifoWd;
	// Black on an empty pop
	if (pixelPop)
		rdPixel <= popOk ? mem[rdPtr] : '0;
end

//------------------------------
// Pointers, level and flags
//------------------------------
always_ff @(posedge sClk)
begin
	if (rst)
	begin
		wrPtr     <= '0;
		rdPtr     <= '0;
		level     <= '0;
		creditRet <= 1'b0;
		primed    <= 1'b0;
		underrun  <= 1'b0;
	end
	else
	begin
		if (fifoWe)
			wrPtr <= wrPtr + 1'b1;
		if (popOk)
			rdPtr <= rdPtr + 1'b1;
		level     <= level + fifoWe - popOk;
		// One credit per drained word
		creditRet <= popOk;
		// Sticky until reset
		if (level == (ptrBits + 1)'(fifoDepth))
			primed <= 1'b1;
		if (pixelPop && level == '0)
			underrun <= 1'b1;
	end
end

endmodule

// File: logic/videoSyncGen.sv
//------------------------------
// Panel timing scan, started once the FIFO is primed
// Sync and de leave one register late, in step with rdPixel
//------------------------------
module videoSyncGen import videoPkg::*;
(
	input  logic sClk,
	input  logic rst,
	input  logic primed,
	output logic pixelPop,
	output logic hSync,
	output logic vSync,
	output logic de
);

hCountT hCount;
vCountT vCount;
logic   lineEnd;
logic   frameEnd;
logic   hSyncNow;
logic   vSyncNow;

assign lineEnd  = (hCount == hCountT'(hTotal - 1));
assign frameEnd = (vCount == vCountT'(vTotal - 1));

//------------------------------
// Scan counters
//------------------------------
always_ff @(posedge sClk)
begin
	// Parked at the frame origin until the FIFO fills
	if (rst || !primed)
	begin
		hCount <= '0;
		vCount <= '0;
	end
	else if (lineEnd)
	begin
		hCount <= '0;
		vCount <= frameEnd ? '0 : vCount + 1'b1;
	end
	else
		hCount <= hCount + 1'b1;
end

//------------------------------
// Position decode
//------------------------------
// Active area pops one pixel per clock
assign pixelPop = primed
	&& (hCount < hCountT'(hActive))
	&& (vCount < vCountT'(vActive));

assign hSyncNow = (hCount >= hCountT'(hSyncStart)) && (hCount < hCountT'(hSyncEnd));
assign vSyncNow = (vCount >= vCountT'(vSyncStart)) && (vCount < vCountT'(vSyncEnd));

// Match the FIFO read latency
always_ff @(posedge sClk)
begin
	if (rst)
	begin
		hSync <= 1'b0;
		vSync <= 1'b0;
		de    <= 1'b0;
	end
	else
	begin
		hSync <= hSyncNow;
		vSync <= vSyncNow;
		de    <= pixelPop;
	end
end

endmodule

// File: logic/dutyGenerator.sv
//------------------------------
// Backlight PWM, 256 clock period
//------------------------------
module dutyGenerator import videoPkg::*;
(
	input  logic sClk,
	input  logic rst,
	input  dutyT blDuty,
	output logic pwm
);

// Free running period counter
dutyT phase;

always_ff @(posedge sClk)
begin
	if (rst)
	begin
		phase <= '0;
		pwm   <= 1'b0;
	end
	else
	begin
		phase <= phase + 1'b1;
		// High for blDuty counts out of 256
		pwm   <= (phase < blDuty);
	end
end

endmodule

// File: logic/videoTxUnit.sv
//------------------------------
// TFT video transmit unit, top level
// Generator, frame buffer DMA, pixel FIFO, scan and backlight
//------------------------------
module videoTxUnit import videoPkg::*;
(
	input  logic       sClk,
	input  logic       rst,
	input  logic       dmaEn,
	input  logic       memRdy,
	input  logic       sceneFadeIn,
	input  logic       sceneFadeOut,
	input  logic [6:0] sceneStep,
	input  dutyT       blDuty,
	output colorT      tftColorR,
	output colorT      tftColorG,
	output colorT      tftColorB,
	output logic       tftHSync,
	output logic       tftVSync,
	output logic       tftDe,
	output logic       tftBackLight,
	output logic       sceneAlphaMax,
	output logic       sceneAlphaMin,
	output logic       underrun
);

// Generator to DMA
pixelT pixel;
logic  pixelWe;
logic  dmaFull;
// DMA to FIFO
pixelT fifoWd;
logic  fifoWe;
logic  creditRet;
// FIFO to scan
pixelT rdPixel;
logic  pixelPop;
logic  primed;

//------------------------------
// Pixel source and frame buffer
//------------------------------
videoPixelGen i_pixelGen (
	.sClk          (sClk),
	.rst           (rst),
	.dmaEn         (dmaEn),
	.sceneFadeIn   (sceneFadeIn),
	.sceneFadeOut  (sceneFadeOut),
	.sceneStep     (sceneStep),
	.dmaFull       (dmaFull),
	.pixel         (pixel),
	.pixelWe       (pixelWe),
	.sceneAlphaMax (sceneAlphaMax),
	.sceneAlphaMin (sceneAlphaMin)
);

videoDma i_dma (
	.sClk      (sClk),
	.rst       (rst),
	.pixel     (pixel),
	.pixelWe   (pixelWe),
	.memRdy    (memRdy),
	.creditRet (creditRet),
	.dmaFull   (dmaFull),
	.fifoWd    (fifoWd),
	.fifoWe    (fifoWe)
);

//------------------------------
// Display side
//------------------------------
videoPixelFifo i_fifo (
	.sClk      (sClk),
	.rst       (rst),
	.fifoWd    (fifoWd),
	.fifoWe    (fifoWe),
	.pixelPop  (pixelPop),
	.rdPixel   (rdPixel),
	.creditRet (creditRet),
	.primed    (primed),
	.underrun  (underrun)
);

videoSyncGen i_syncGen (
	.sClk     (sClk),
	.rst      (rst),
	.primed   (primed),
	.pixelPop (pixelPop),
	.hSync    (tftHSync),
	.vSync    (tftVSync),
	.de       (tftDe)
);

dutyGenerator i_blGen (
	.sClk   (sClk),
	.rst    (rst),
	.blDuty (blDuty),
	.pwm    (tftBackLight)
);

// Alpha nibble stops here
assign tftColorR = rdPixel[11:8];
assign tftColorG = rdPixel[7:4];
assign tftColorB = rdPixel[3:0];

endmodule

// File: tb/videoTx_chk.sv
//------------------------------
// Protocol assertions, bound into videoTxUnit
// Scan timing, FIFO health, fade flags and credit flow
//------------------------------
module videoTx_chk import videoPkg::*;
(
	input logic                       sClk,
	input logic                       rst,
	input dmaOpT                      dmaOp,
	input logic                       fifoWe,
	input logic [$clog2(fifoDepth):0] fifoLevel,
	input logic                       tftDe,
	input logic                       tftHSync,
	input logic                       tftVSync,
	input logic                       underrun,
	input logic                       sceneAlphaMax,
	input logic                       sceneAlphaMin
);

timeunit 1ns;
timeprecision 1ps;

// Pixels only outside both sync pulses
deOutsideSync: assert property (@(posedge sClk) disable iff (rst)
	tftDe |-> !(tftHSync || tftVSync))
	else $error("tftDe high during a sync pulse");

// Credit flow keeps the FIFO fed
noUnderrun: assert property (@(posedge sClk) disable iff (rst)
	!$rose(underrun))
	else $error("underrun rose during the scan");

// Alpha is either saturated high, low or in between
alphaFlagsExclusive: assert property (@(posedge sClk) disable iff (rst)
	!(sceneAlphaMax && sceneAlphaMin))
	else $error("sceneAlphaMax and sceneAlphaMin both high");

// A read always finds room in the FIFO for its push
readHasFifoRoom: assert property (@(posedge sClk) disable iff (rst)
	dmaOp == opRead |-> fifoLevel + fifoWe < fifoDepth)
	else $error("frame buffer read issued without room in the pixel FIFO");

endmodule

bind videoTxUnit videoTx_chk i_chk (
	.sClk          (sClk),
	.rst           (rst),
	.dmaOp         (i_dma.dmaOp),
	.fifoWe        (fifoWe),
	.fifoLevel     (i_fifo.level),
	.tftDe         (tftDe),
	.tftHSync      (tftHSync),
	.tftVSync      (tftVSync),
	.underrun      (underrun),
	.sceneAlphaMax (sceneAlphaMax),
	.sceneAlphaMin (sceneAlphaMin)
);

// File: tb/videoTxUnitTb.sv
//------------------------------
// Testbench for videoTxUnit with random memory stalls
// Checks raster pixels, scan geometry, scene fades and backlight PWM
//------------------------------
module videoTxUnitTb import videoPkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int frameCycles = hTotal * vTotal;
localparam int checkFrames = 6;
// A generated frame may take about two display frames
localparam int fadeFrames  = 48;
localparam int holdFrames  = 2;
// Reset, checked frames, both fades with holds, three PWM windows
localparam int watchCycles = 16
	+ (checkFrames + 2 * (fadeFrames + holdFrames)) * frameCycles
	+ 3 * 300 + 2000;

logic       sClk;
logic       rst;
logic       dmaEn;
logic       memRdy;
logic       sceneFadeIn;
logic       sceneFadeOut;
logic [6:0] sceneStep;
dutyT       blDuty;
colorT      tftColorR;
colorT      tftColorG;
colorT      tftColorB;
logic       tftHSync;
logic       tftVSync;
logic       tftDe;
logic       tftBackLight;
logic       sceneAlphaMax;
logic       sceneAlphaMin;
logic       underrun;

integer      seed = 74;
int          dutyList [3] = '{0, 64, 200};
// Scan monitor state
int          frameCount;
int          pixIdx;
int          lineDe;
int          activeLines;
int          hCycles;
logic        hSeen;
logic        lastHSync;
logic        lastVSync;
logic [11:0] expColor;

videoTxUnit i_dut (
	.sClk          (sClk),
	.rst           (rst),
	.dmaEn         (dmaEn),
	.memRdy        (memRdy),
	.sceneFadeIn   (sceneFadeIn),
	.sceneFadeOut  (sceneFadeOut),
	.sceneStep     (sceneStep),
	.blDuty        (blDuty),
	.tftColorR     (tftColorR),
	.tftColorG     (tftColorG),
	.tftColorB     (tftColorB),
	.tftHSync      (tftHSync),
	.tftVSync      (tftVSync),
	.tftDe         (tftDe),
	.tftBackLight  (tftBackLight),
	.sceneAlphaMax (sceneAlphaMax),
	.sceneAlphaMin (sceneAlphaMin),
	.underrun      (underrun)
);

//------------------------------
// Helpers
//------------------------------
task automatic failRun(input string msg);
	$display("%s", msg);
	$display("CHECKS FAILED");
	$fatal(1, "run stopped at %0t", $time);
endtask

task automatic checkValue(input string name, input int got, input int exp);
	assert (got == exp)
	else failRun($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// Panel colour {R, G, B} at raster position x, y
function automatic logic [11:0] refColor(input int x, input int y);
	colorT r;
	colorT g;
	r = colorT'(y);
	g = colorT'(x);
	return {r, g, r ^ g};
endfunction

//------------------------------
// Clock, memory grant, watchdog
//------------------------------
initial
begin
	sClk = 1'b0;
	forever
		#10 sClk = ~sClk;
end

// Grant about three cycles in four
initial
begin
	memRdy = 1'b0;
	forever
	begin
		@(posedge sClk);
		memRdy <= ($random(seed) & 3) != 0;
	end
end

initial
begin
	repeat (watchCycles)
		@(posedge sClk);
	failRun("Run timed out before all tests finished");
end

//------------------------------
// Scan monitor, sampled mid cycle
//------------------------------
always @(negedge sClk)
begin
	if (rst)
	begin
		frameCount  = 0;
		pixIdx      = 0;
		lineDe      = 0;
		activeLines = 0;
		hCycles     = 0;
		hSeen       = 1'b0;
	end
	else
	begin
		assert (!underrun) else failRun("FIFO underrun during the scan");
		assert (!(tftDe && (tftHSync || tftVSync)))
		else failRun("tftDe high during a sync pulse");
		assert (!(sceneAlphaMax && sceneAlphaMin))
		else failRun("Both alpha flags high at once");
		if (tftDe)
		begin
			// Position from the count of de cycles in this frame
			expColor = refColor(pixIdx % hActive, pixIdx / hActive);
			checkValue("tftColorR", tftColorR, expColor[11:8]);
			checkValue("tftColorG", tftColorG, expColor[7:4]);
			checkValue("tftColorB", tftColorB, expColor[3:0]);
			pixIdx++;
			lineDe++;
		end
		if (tftHSync && !lastHSync)
		begin
			if (hSeen)
				checkValue("tftHSync period", hCycles, hTotal);
			// Blank lines carry no de
			if (lineDe != 0)
			begin
				checkValue("tftDe per line", lineDe, hActive);
				activeLines++;
			end
			hSeen   = 1'b1;
			hCycles = 0;
			lineDe  = 0;
		end
		hCycles++;
		if (tftVSync && !lastVSync)
		begin
			checkValue("tftDe per frame", pixIdx, hActive * vActive);
			checkValue("active lines per frame", activeLines, vActive);
			frameCount++;
			pixIdx      = 0;
			activeLines = 0;
		end
	end
	lastHSync = tftHSync;
	lastVSync = tftVSync;
end

//------------------------------
// Test sequence
//------------------------------
initial
begin
	int limit;
	int highCount;
	rst          = 1'b1;
	dmaEn        = 1'b0;
	sceneFadeIn  = 1'b0;
	sceneFadeOut = 1'b0;
	sceneStep    = 7'd1;
	blDuty       = '0;
	repeat (15)
		@(posedge sClk);
	@(negedge sClk);
	// Reset state
	checkValue("tftHSync", tftHSync, 0);
	checkValue("tftVSync", tftVSync, 0);
	checkValue("tftDe", tftDe, 0);
	checkValue("underrun", underrun, 0);
	checkValue("sceneAlphaMax", sceneAlphaMax, 0);
	checkValue("sceneAlphaMin", sceneAlphaMin, 1);
	checkValue("tftBackLight", tftBackLight, 0);
	@(posedge sClk);
	rst         <= 1'b0;
	dmaEn       <= 1'b1;
	sceneFadeIn <= 1'b1;

	// Pixel checks run in the monitor across all frames
	wait (frameCount >= checkFrames);
	@(negedge sClk);
	checkValue("sceneAlphaMin", sceneAlphaMin, 0);

	// Fade in up to saturation
	limit = fadeFrames * frameCycles;
	while (!sceneAlphaMax && limit > 0)
	begin
		@(negedge sClk);
		limit--;
	end
	assert (sceneAlphaMax) else failRun("sceneAlphaMax did not rise during the fade in");
	repeat (holdFrames * frameCycles)
		@(negedge sClk);
	checkValue("sceneAlphaMax", sceneAlphaMax, 1);

	// Fade back out to zero
	@(posedge sClk);
	sceneFadeIn  <= 1'b0;
	sceneFadeOut <= 1'b1;
	limit = fadeFrames * frameCycles;
	while (!sceneAlphaMin && limit > 0)
	begin
		@(negedge sClk);
		limit--;
	end
	assert (sceneAlphaMin) else failRun("sceneAlphaMin did not return during the fade out");
	checkValue("sceneAlphaMax", sceneAlphaMax, 0);
	repeat (holdFrames * frameCycles)
		@(negedge sClk);
	checkValue("sceneAlphaMin", sceneAlphaMin, 1);

	// Backlight duty over one full PWM period
	for (int i = 0; i < 3; i++)
	begin
		@(posedge sClk);
		blDuty <= dutyT'(dutyList[i]);
		repeat (3)
			@(posedge sClk);
		highCount = 0;
		repeat (256)
		begin
			@(negedge sClk);
			if (tftBackLight)
				highCount++;
		end
		checkValue("tftBackLight high cycles", highCount, dutyList[i]);
	end

	$display("ALL CHECKS PASSED");
	$finish;
end

endmodule

// File: sources.f
logic/videoPkg.sv
logic/videoPixelGen.sv
logic/videoDma.sv
logic/videoPixelFifo.sv
logic/videoSyncGen.sv
logic/dutyGenerator.sv
logic/videoTxUnit.sv
tb/videoTx_chk.sv
tb/videoTxUnitTb.sv

// File: run.sh
#!/bin/sh
# Build the videoTxUnit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module videoTxUnitTb -Mdir obj_dir -o videoTxSim -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/videoTxSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
